// ==== clock_pkg.sv ====
package clock_pkg;

  typedef enum logic [3:0] {
    TIME_DISP         = 4'd0,
    TIME_EDIT_SECOND  = 4'd2,
    TIME_EDIT_MINUTE  = 4'd3,
    TIME_EDIT_HOUR    = 4'd4,
    TIMER_DISP        = 4'd12,
    TIMER_EDIT_SECOND = 4'd13,
    TIMER_EDIT_MINUTE = 4'd14,
    TIMER_EDIT_HOUR   = 4'd15
  } clock_mode_t;

  typedef struct packed {
    logic [7:0] hour;    // bcd
    logic [7:0] minute;
    logic [7:0] second;
  } hms_t;

  typedef logic [3:0] digit_t;
  typedef digit_t [7:0] led_frame_t;  // [7] is leftmost
  typedef logic [7:0] blink_t;

  typedef struct packed {
    logic up;
    logic down;
  } btn_press_t;

  localparam digit_t SEPARATOR_DIGIT = 4'd10;  // dash

  localparam logic [7:0] HOUR_MAX_BCD   = 8'h23;
  localparam logic [7:0] MINUTE_MAX_BCD = 8'h59;
  localparam logic [7:0] SECOND_MAX_BCD = 8'h59;

  localparam blink_t BLINK_SECOND = 8'b0000_0011;
  localparam blink_t BLINK_MINUTE = 8'b0001_1000;
  localparam blink_t BLINK_HOUR   = 8'b1100_0000;
  localparam blink_t BLINK_ALL    = 8'b1111_1111;
  localparam blink_t BLINK_NONE   = 8'b0000_0000;

  function automatic logic [7:0] bcd_inc_wrap(input logic [7:0] value,
                                              input logic [7:0] limit);
    if (value == limit) begin
      return 8'h00;
    end else if (value[3:0] == 4'd9) begin
      return {value[7:4] + 4'd1, 4'd0};  // carry into tens
    end
    return value + 8'd1;
  endfunction

  // step down one, wrapping from zero back to the limit
  function automatic logic [7:0] bcd_dec_wrap(input logic [7:0] value,
                                              input logic [7:0] limit);
    if (value == 8'h00) begin
      return limit;
    end else if (value[3:0] == 4'd0) begin
      return {value[7:4] - 4'd1, 4'd9};
    end
    return value - 8'd1;
  endfunction

  function automatic hms_t hms_tick_up(input hms_t t);
    hms_t result;
    result        = t;
    result.second = bcd_inc_wrap(t.second, SECOND_MAX_BCD);
    if (t.second == SECOND_MAX_BCD) begin
      result.minute = bcd_inc_wrap(t.minute, MINUTE_MAX_BCD);
      if (t.minute == MINUTE_MAX_BCD) begin
        result.hour = bcd_inc_wrap(t.hour, HOUR_MAX_BCD);
      end
    end
    return result;
  endfunction

  function automatic hms_t hms_tick_down(input hms_t t);
    hms_t result;
    result        = t;
    result.second = bcd_dec_wrap(t.second, SECOND_MAX_BCD);
    if (t.second == 8'h00) begin
      result.minute = bcd_dec_wrap(t.minute, MINUTE_MAX_BCD);  // borrow
      if (t.minute == 8'h00) begin
        result.hour = bcd_dec_wrap(t.hour, HOUR_MAX_BCD);
      end
    end
    return result;
  endfunction

endpackage

// ==== button_edge.sv ====
module button_edge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  up_btn,    // active low
  input  logic                  down_btn,  // active low
  output clock_pkg::btn_press_t press
);

  logic [1:0] up_hist;    // [1] older sample
  logic [1:0] down_hist;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_hist   <= 2'b11;  // released
      down_hist <= 2'b11;
    end else begin
      up_hist   <= {up_hist[0], up_btn};
      down_hist <= {down_hist[0], down_btn};
    end
  end

  // released then pressed, high for one cycle only
  always_comb begin
    press.up   = (up_hist == 2'b10);
    press.down = (down_hist == 2'b10);
  end

endmodule

// ==== time_keeper.sv ====
module time_keeper (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_pkg::clock_mode_t mode,
  input  logic                   sec_tick,
  input  clock_pkg::btn_press_t  press,
  output clock_pkg::hms_t        time_now,
  output clock_pkg::hms_t        time_edit
);

  clock_pkg::clock_mode_t prev_mode;
  logic                   prev_was_edit;
  logic                   commit;

  always_comb begin
    case (prev_mode)
      clock_pkg::TIME_EDIT_SECOND,
      clock_pkg::TIME_EDIT_MINUTE,
      clock_pkg::TIME_EDIT_HOUR: prev_was_edit = 1'b1;
      default:                   prev_was_edit = 1'b0;
    endcase
  end

  // edit just ended, edited copy becomes the time
  assign commit = (mode == clock_pkg::TIME_DISP) && prev_was_edit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_mode <= clock_pkg::TIME_DISP;
    end else begin
      prev_mode <= mode;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_now <= '0;
    end else if (commit) begin
      time_now <= time_edit;  // wins over a tick on the same edge
    end else if (sec_tick) begin
      time_now <= clock_pkg::hms_tick_up(time_now);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      time_edit <= '0;
    end else begin
      case (mode)
        clock_pkg::TIME_DISP: begin
          if (!commit) begin
            time_edit <= time_now;
          end
        end
        clock_pkg::TIME_EDIT_SECOND: begin
          if (press.down) begin
            time_edit.second <= clock_pkg::bcd_inc_wrap(time_edit.second,
                                                        clock_pkg::SECOND_MAX_BCD);
          end
        end
        clock_pkg::TIME_EDIT_MINUTE: begin
          if (press.down) begin
            time_edit.minute <= clock_pkg::bcd_inc_wrap(time_edit.minute,
                                                        clock_pkg::MINUTE_MAX_BCD);
          end
        end
        clock_pkg::TIME_EDIT_HOUR: begin
          if (press.down) begin
            time_edit.hour <= clock_pkg::bcd_inc_wrap(time_edit.hour,
                                                      clock_pkg::HOUR_MAX_BCD);
          end
        end
        default: begin
          time_edit <= time_edit;  // timer modes leave the copy alone
        end
      endcase
    end
  end

endmodule

// ==== countdown_timer.sv ====
module countdown_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_pkg::clock_mode_t mode,
  input  logic                   sec_tick,
  input  clock_pkg::btn_press_t  press,
  output clock_pkg::hms_t        timer_now,
  output clock_pkg::hms_t        timer_edit,
  output logic                   timer_ringing
);

  clock_pkg::clock_mode_t prev_mode;
  logic                   prev_was_edit;
  logic                   load;
  logic                   in_disp;
  logic                   running;

  always_comb begin
    case (prev_mode)
      clock_pkg::TIMER_EDIT_SECOND,
      clock_pkg::TIMER_EDIT_MINUTE,
      clock_pkg::TIMER_EDIT_HOUR: prev_was_edit = 1'b1;
      default:                    prev_was_edit = 1'b0;
    endcase
  end

  assign in_disp = (mode == clock_pkg::TIMER_DISP);
  assign load    = in_disp && prev_was_edit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_mode     <= clock_pkg::TIME_DISP;
      timer_now     <= '0;
      running       <= 1'b0;
      timer_ringing <= 1'b0;
    end else begin
      prev_mode <= mode;
      if (load) begin
        timer_now     <= timer_edit;
        running       <= 1'b0;
        timer_ringing <= 1'b0;
      end else if (in_disp && press.up) begin
        if (running) begin
          running <= 1'b0;  // pause
        end else begin
          timer_now     <= '0;
          timer_ringing <= 1'b0;
        end
      end else if (in_disp && press.down && !running) begin
        if (timer_ringing) begin
          timer_ringing <= 1'b0;  // silence only
        end else begin
          running <= 1'b1;
        end
      end else if (running && sec_tick) begin
        if (timer_now == '0) begin
          running       <= 1'b0;
          timer_ringing <= 1'b1;
        end else begin
          timer_now <= clock_pkg::hms_tick_down(timer_now);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_edit <= '0;
    end else begin
      case (mode)
        clock_pkg::TIMER_DISP: begin
          timer_edit <= timer_now;
        end
        clock_pkg::TIMER_EDIT_SECOND: begin
          if (press.down) begin
            timer_edit.second <= clock_pkg::bcd_inc_wrap(timer_edit.second,
                                                         clock_pkg::SECOND_MAX_BCD);
          end
        end
        clock_pkg::TIMER_EDIT_MINUTE: begin
          if (press.down) begin
            timer_edit.minute <= clock_pkg::bcd_inc_wrap(timer_edit.minute,
                                                         clock_pkg::MINUTE_MAX_BCD);
          end
        end
        clock_pkg::TIMER_EDIT_HOUR: begin
          if (press.down) begin
            timer_edit.hour <= clock_pkg::bcd_inc_wrap(timer_edit.hour,
                                                       clock_pkg::HOUR_MAX_BCD);
          end
        end
        default: begin
          timer_edit <= timer_edit;
        end
      endcase
    end
  end

endmodule

// ==== display_mux.sv ====
module display_mux (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_pkg::clock_mode_t mode,
  input  clock_pkg::hms_t        time_now,
  input  clock_pkg::hms_t        time_edit,
  input  clock_pkg::hms_t        timer_now,
  input  clock_pkg::hms_t        timer_edit,
  input  logic                   timer_ringing,
  output clock_pkg::led_frame_t  digits,
  output clock_pkg::blink_t      blink,
  output logic                   ring
);

  clock_pkg::hms_t       shown;
  clock_pkg::blink_t     mask;
  clock_pkg::led_frame_t frame;

  always_comb begin
    case (mode)
      clock_pkg::TIME_EDIT_SECOND: begin
        shown = time_edit;
        mask  = clock_pkg::BLINK_SECOND;
      end
      clock_pkg::TIME_EDIT_MINUTE: begin
        shown = time_edit;
        mask  = clock_pkg::BLINK_MINUTE;
      end
      clock_pkg::TIME_EDIT_HOUR: begin
        shown = time_edit;
        mask  = clock_pkg::BLINK_HOUR;
      end
      clock_pkg::TIMER_DISP: begin
        shown = timer_now;
        mask  = timer_ringing ? clock_pkg::BLINK_ALL : clock_pkg::BLINK_NONE;
      end
      clock_pkg::TIMER_EDIT_SECOND: begin
        shown = timer_edit;
        mask  = clock_pkg::BLINK_SECOND;
      end
      clock_pkg::TIMER_EDIT_MINUTE: begin
        shown = timer_edit;
        mask  = clock_pkg::BLINK_MINUTE;
      end
      clock_pkg::TIMER_EDIT_HOUR: begin
        shown = timer_edit;
        mask  = clock_pkg::BLINK_HOUR;
      end
      default: begin  // TIME_DISP and unused codes
        shown = time_now;
        mask  = clock_pkg::BLINK_NONE;
      end
    endcase
  end

  // hh-mm-ss
  always_comb begin
    frame[7] = shown.hour[7:4];
    frame[6] = shown.hour[3:0];
    frame[5] = clock_pkg::SEPARATOR_DIGIT;
    frame[4] = shown.minute[7:4];
    frame[3] = shown.minute[3:0];
    frame[2] = clock_pkg::SEPARATOR_DIGIT;
    frame[1] = shown.second[7:4];
    frame[0] = shown.second[3:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digits <= '0;
      blink  <= clock_pkg::BLINK_NONE;
      ring   <= 1'b0;
    end else begin
      digits <= frame;
      blink  <= mask;
      ring   <= timer_ringing;  // aligned with the frame
    end
  end

endmodule

// ==== clock_face_top.sv ====
module clock_face_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sec_tick,
  input  clock_pkg::clock_mode_t mode,
  input  logic                   up_btn,
  input  logic                   down_btn,
  output clock_pkg::led_frame_t  digits,
  output clock_pkg::blink_t      blink,
  output logic                   ring
);

  clock_pkg::btn_press_t press;
  clock_pkg::hms_t       time_now;
  clock_pkg::hms_t       time_edit;
  clock_pkg::hms_t       timer_now;
  clock_pkg::hms_t       timer_edit;
  logic                  timer_ringing;

  button_edge u_button_edge (
    .clk      (clk),
    .rst_n    (rst_n),
    .up_btn   (up_btn),
    .down_btn (down_btn),
    .press    (press)
  );

  time_keeper u_time_keeper (
    .clk       (clk),
    .rst_n     (rst_n),
    .mode      (mode),
    .sec_tick  (sec_tick),
    .press     (press),
    .time_now  (time_now),
    .time_edit (time_edit)
  );

  countdown_timer u_countdown_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .mode          (mode),
    .sec_tick      (sec_tick),
    .press         (press),
    .timer_now     (timer_now),
    .timer_edit    (timer_edit),
    .timer_ringing (timer_ringing)
  );

  display_mux u_display_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .mode          (mode),
    .time_now      (time_now),
    .time_edit     (time_edit),
    .timer_now     (timer_now),
    .timer_edit    (timer_edit),
    .timer_ringing (timer_ringing),
    .digits        (digits),
    .blink         (blink),
    .ring          (ring)
  );

endmodule

// ==== tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef enum {EV_TICK, EV_DOWN, EV_UP, EV_MODE} stim_t;

// reference state, every time held as seconds of the day
int unsigned ref_time;
int unsigned ref_time_edit;
int unsigned ref_timer;
int unsigned ref_timer_edit;
bit          ref_running;
bit          ref_ringing;
int          err_count;

// -1 outside the edit modes
function automatic int field_of(input clock_pkg::clock_mode_t m);
  case (m)
    clock_pkg::TIME_EDIT_SECOND, clock_pkg::TIMER_EDIT_SECOND: return 0;
    clock_pkg::TIME_EDIT_MINUTE, clock_pkg::TIMER_EDIT_MINUTE: return 1;
    clock_pkg::TIME_EDIT_HOUR, clock_pkg::TIMER_EDIT_HOUR:     return 2;
    default:                                                   return -1;
  endcase
endfunction

function automatic bit is_time_edit(input clock_pkg::clock_mode_t m);
  return field_of(m) >= 0 && m != clock_pkg::TIMER_EDIT_SECOND &&
         m != clock_pkg::TIMER_EDIT_MINUTE && m != clock_pkg::TIMER_EDIT_HOUR;
endfunction

function automatic bit is_timer_edit(input clock_pkg::clock_mode_t m);
  return field_of(m) >= 0 && !is_time_edit(m);
endfunction

// one field up by one, wrapping within that field only
function automatic int unsigned bump_field(input int unsigned t, input int field);
  int unsigned h;
  int unsigned m;
  int unsigned s;
  h = t / 3600;
  m = (t / 60) % 60;
  s = t % 60;
  case (field)
    0:       s = (s + 1) % 60;
    1:       m = (m + 1) % 60;
    default: h = (h + 1) % 24;
  endcase
  return h * 3600 + m * 60 + s;
endfunction

function automatic void apply_event(input stim_t kind, input clock_pkg::clock_mode_t prev,
                                    input clock_pkg::clock_mode_t cur);
  case (kind)
    EV_TICK: begin
      ref_time = (ref_time + 1) % 86400;
      if (ref_running && ref_timer == 0) begin
        ref_running = 1'b0;  // tick that finds zero rings
        ref_ringing = 1'b1;
      end else if (ref_running) begin
        ref_timer = ref_timer - 1;
      end
    end
    EV_DOWN: begin
      if (is_time_edit(cur)) begin
        ref_time_edit = bump_field(ref_time_edit, field_of(cur));
      end else if (is_timer_edit(cur)) begin
        ref_timer_edit = bump_field(ref_timer_edit, field_of(cur));
      end else if (cur == clock_pkg::TIMER_DISP && !ref_running) begin
        if (ref_ringing) begin
          ref_ringing = 1'b0;
        end else begin
          ref_running = 1'b1;
        end
      end
    end
    EV_UP: begin
      if (cur == clock_pkg::TIMER_DISP && ref_running) begin
        ref_running = 1'b0;  // pause
      end else if (cur == clock_pkg::TIMER_DISP) begin
        ref_timer   = 0;
        ref_ringing = 1'b0;
      end
    end
    default: begin
      if (cur == clock_pkg::TIME_DISP && is_time_edit(prev)) begin
        ref_time = ref_time_edit;  // commit
      end
      if (cur == clock_pkg::TIMER_DISP && is_timer_edit(prev)) begin
        ref_timer   = ref_timer_edit;
        ref_running = 1'b0;
        ref_ringing = 1'b0;
      end
    end
  endcase
  // edit copies track the live value while displayed
  if (cur == clock_pkg::TIME_DISP) begin
    ref_time_edit = ref_time;
  end
  if (cur == clock_pkg::TIMER_DISP) begin
    ref_timer_edit = ref_timer;
  end
endfunction

function automatic clock_pkg::led_frame_t frame_of(input int unsigned t);
  clock_pkg::led_frame_t f;
  int unsigned h;
  int unsigned m;
  int unsigned s;
  h    = t / 3600;
  m    = (t / 60) % 60;
  s    = t % 60;
  f[7] = 4'(h / 10);
  f[6] = 4'(h % 10);
  f[5] = 4'd10;  // dash
  f[4] = 4'(m / 10);
  f[3] = 4'(m % 10);
  f[2] = 4'd10;
  f[1] = 4'(s / 10);
  f[0] = 4'(s % 10);
  return f;
endfunction

function automatic clock_pkg::led_frame_t shown_frame(input clock_pkg::clock_mode_t m);
  if (is_time_edit(m)) return frame_of(ref_time_edit);
  if (is_timer_edit(m)) return frame_of(ref_timer_edit);
  if (m == clock_pkg::TIMER_DISP) return frame_of(ref_timer);
  return frame_of(ref_time);
endfunction

function automatic clock_pkg::blink_t mask_for(input clock_pkg::clock_mode_t m,
                                               input bit ringing);
  case (field_of(m))
    0:       return 8'b0000_0011;
    1:       return 8'b0001_1000;
    2:       return 8'b1100_0000;
    default: return (m == clock_pkg::TIMER_DISP && ringing) ? 8'hff : 8'h00;
  endcase
endfunction

task automatic check_frame(input clock_pkg::led_frame_t got,
                           input clock_pkg::led_frame_t want);
  if (got !== want) begin
    err_count++;
    $display("Mismatch digits: expected %h, got %h at %0t", want, got, $time);
  end
endtask

task automatic check_blink(input clock_pkg::blink_t got, input clock_pkg::blink_t want);
  if (got !== want) begin
    err_count++;
    $display("Mismatch blink: expected %h, got %h at %0t", want, got, $time);
  end
endtask

task automatic check_ring(input logic got, input logic want);
  if (got !== want) begin
    err_count++;
    $display("Mismatch ring: expected %h, got %h at %0t", want, got, $time);
  end
endtask

`endif

// ==== tb_clock_face.sv ====
module tb_clock_face;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STEP_CYCLES = 7;  // drive, release, 4 idle, compare
  localparam int HOLD_CYCLES = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   sec_tick;
  clock_pkg::clock_mode_t mode;
  logic                   up_btn;
  logic                   down_btn;
  clock_pkg::led_frame_t  digits;
  clock_pkg::blink_t      blink;
  logic                   ring;

  `include "tb_model.svh"

  clock_pkg::led_frame_t exp_frame;
  clock_pkg::blink_t     exp_blink;
  logic                  exp_ring;
  logic                  check_now;
  int                    cycle_count;
  int                    cycle_limit;
  int                    tests_passed;
  int                    tests_failed;
  int                    errs_at_start;

  clock_face_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .sec_tick (sec_tick),
    .mode     (mode),
    .up_btn   (up_btn),
    .down_btn (down_btn),
    .digits   (digits),
    .blink    (blink),
    .ring     (ring)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (check_now) begin
      check_frame(digits, exp_frame);
      check_blink(blink, exp_blink);
      check_ring(ring, exp_ring);
    end
  end

  task automatic request_check();
    exp_frame <= shown_frame(mode);
    exp_blink <= mask_for(mode, ref_ringing);
    exp_ring  <= ref_ringing;
    check_now <= 1'b1;
    @(negedge clk);
    check_now <= 1'b0;
  endtask

  // one-cycle tick or button press, then settle and compare
  task automatic pulse(input stim_t kind);
    @(negedge clk);
    case (kind)
      EV_TICK: sec_tick = 1'b1;
      EV_DOWN: down_btn = 1'b0;
      default: up_btn = 1'b0;
    endcase
    @(negedge clk);
    sec_tick = 1'b0;
    down_btn = 1'b1;
    up_btn   = 1'b1;
    apply_event(kind, mode, mode);
    repeat (4) @(negedge clk);
    request_check();
  endtask

  task automatic pulses(input stim_t kind, input int count);
    repeat (count) pulse(kind);
  endtask

  task automatic set_mode(input clock_pkg::clock_mode_t next);
    clock_pkg::clock_mode_t prev;
    @(negedge clk);
    prev = mode;
    mode = next;
    apply_event(EV_MODE, prev, next);
    repeat (4) @(negedge clk);
    request_check();
  endtask

  task automatic hold_down(input int cycles);
    @(negedge clk);
    down_btn = 1'b0;
    repeat (cycles) @(negedge clk);
    down_btn = 1'b1;
    apply_event(EV_DOWN, mode, mode);  // a long hold is still one press
    repeat (4) @(negedge clk);
    request_check();
  endtask

  task automatic edit_time_to(input int unsigned target);
    set_mode(clock_pkg::TIME_EDIT_HOUR);
    pulses(EV_DOWN, (target / 3600 + 24 - ref_time_edit / 3600) % 24);
    set_mode(clock_pkg::TIME_EDIT_MINUTE);
    pulses(EV_DOWN, ((target / 60) % 60 + 60 - (ref_time_edit / 60) % 60) % 60);
    set_mode(clock_pkg::TIME_EDIT_SECOND);
    pulses(EV_DOWN, (target % 60 + 60 - ref_time_edit % 60) % 60);
    set_mode(clock_pkg::TIME_DISP);
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  initial begin
    int n_tick;
    int n_roll;
    int n_sec;
    int n_min;
    int n_hour;
    int dur;
    int n_run;
    rst_n          = 1'b0;
    sec_tick       = 1'b0;
    mode           = clock_pkg::TIME_DISP;
    up_btn         = 1'b1;
    down_btn       = 1'b1;
    check_now     <= 1'b0;
    cycle_count    = 0;
    err_count      = 0;
    errs_at_start  = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    ref_time       = 0;
    ref_time_edit  = 0;
    ref_timer      = 0;
    ref_timer_edit = 0;
    ref_running    = 1'b0;
    ref_ringing    = 1'b0;
    void'($urandom(32'hf6e2_c741));
    n_tick = 5 + $urandom % 60;
    n_roll = 6 + $urandom % 20;  // starts at 23:59:55
    n_sec  = 60 + $urandom % 30;  // at least one wrap per field
    n_min  = 60 + $urandom % 30;
    n_hour = 24 + $urandom % 12;
    dur    = 3 + $urandom % 6;
    n_run  = 1 + $urandom % 10;
    // 200 covers mode changes, fixed presses and up to 141 set-time presses
    cycle_limit = 2 * ((n_tick + n_roll + n_sec + n_min + n_hour + 2 * dur + n_run + 200)
                       * STEP_CYCLES + HOLD_CYCLES + 20);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    request_check();
    pulses(EV_TICK, n_tick);
    edit_time_to(86395);
    pulses(EV_TICK, n_roll);
    finish_test("reset and time of day");

    set_mode(clock_pkg::TIME_EDIT_SECOND);
    pulses(EV_DOWN, n_sec);
    set_mode(clock_pkg::TIME_EDIT_MINUTE);
    pulses(EV_DOWN, n_min);
    set_mode(clock_pkg::TIME_EDIT_HOUR);
    pulses(EV_DOWN, n_hour);
    set_mode(clock_pkg::TIME_DISP);
    pulses(EV_TICK, 2);
    finish_test("time edit and commit");

    set_mode(clock_pkg::TIME_EDIT_MINUTE);
    hold_down(HOLD_CYCLES);
    pulse(EV_UP);
    set_mode(clock_pkg::TIME_DISP);
    finish_test("held button and up press");

    set_mode(clock_pkg::TIMER_DISP);
    set_mode(clock_pkg::TIMER_EDIT_SECOND);
    pulses(EV_DOWN, dur);
    set_mode(clock_pkg::TIMER_DISP);
    pulse(EV_DOWN);  // start
    pulses(EV_TICK, dur + 1);
    pulse(EV_DOWN);  // silence the ring
    finish_test("timer countdown and ring");

    set_mode(clock_pkg::TIMER_EDIT_MINUTE);
    pulses(EV_DOWN, 2);
    set_mode(clock_pkg::TIMER_DISP);
    pulse(EV_DOWN);
    pulses(EV_TICK, n_run);
    pulse(EV_UP);  // pause
    pulses(EV_TICK, 3);
    set_mode(clock_pkg::TIME_DISP);
    pulses(EV_TICK, 2);
    set_mode(clock_pkg::TIMER_DISP);
    pulse(EV_UP);  // back to zero
    finish_test("timer pause and reset");

    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
clock_pkg.sv
button_edge.sv
time_keeper.sv
countdown_timer.sv
display_mux.sv
clock_face_top.sv
tb_clock_face.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the clock face testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module tb_clock_face -o tb_clock_face
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_clock_face > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation binary exited with status $run_status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
